//--- common/icache_pkg.sv
package icache_pkg;

    // ########################################################################
    // Widths that carry a meaning
    // ########################################################################

    typedef logic [31:0] word_t;    // One instruction or one memory word.
    typedef logic [31:0] addr_t;    // Byte address, bits 1..0 are ignored.

    // ########################################################################
    // Default geometry
    // ########################################################################

    localparam int DEF_WAYS       = 4;
    localparam int DEF_SETS       = 16;
    localparam int DEF_LINE_WORDS = 4;

    // ########################################################################
    // Control and stage payloads
    // ########################################################################

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,       // Raise mem_req for the next word of the line.
        MISS_WAIT,      // Wait for mem_ack to rise and then to fall.
        RESPOND,
        FENCE
    } cache_state_t;

    // Tag, index and offset are sliced from the address by the geometry.
    typedef struct packed {
        addr_t addr;
    } fetch_req_t;

    // Registered lookup result; the hit way travels on its own port.
    typedef struct packed {
        logic  hit;
        word_t data;
        addr_t addr;
    } lookup_t;

endpackage

//--- logic/plru_tree.sv
module plru_tree import icache_pkg::*; #(
    parameter int ways   = DEF_WAYS,
    parameter int sets   = DEF_SETS,
    localparam int way_w = $clog2(ways),
    localparam int idx_w = $clog2(sets)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             touch,
    input  logic [way_w-1:0] way,
    input  logic [idx_w-1:0] index,
    output logic [way_w-1:0] victim
);
    // Node n has children 2n+1 and 2n+2; a bit of 1 points to the right.
    logic [ways-2:0] tree [sets];
    logic [ways-2:0] tree_next;

    // Follow the bits from the root down to a leaf.
    always_comb begin
        int node;
        node   = 0;
        victim = '0;
        for (int l = 0; l < way_w; l++) begin
            victim[way_w-1-l] = tree[index][node];
            node = 2 * node + 1 + int'(tree[index][node]);
        end
    end

    // Every node on the path of the used way points to the other half.
    always_comb begin
        int node;
        node      = 0;
        tree_next = tree[index];
        for (int l = 0; l < way_w; l++) begin
            tree_next[node] = ~way[way_w-1-l];
            node = 2 * node + 1 + int'(way[way_w-1-l]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < sets; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            tree[index] <= tree_next;
        end
    end

endmodule

//--- icache/icache_decode.sv
module icache_decode import icache_pkg::*; #(
    parameter int sets       = DEF_SETS,
    parameter int line_words = DEF_LINE_WORDS,
    localparam int idx_w     = $clog2(sets),
    localparam int off_w     = $clog2(line_words)
) (
    input  logic             clk,
    input  logic             rst,
    input  addr_t            fetch_addr,
    input  logic             accept,
    output fetch_req_t       req,
    output logic [idx_w-1:0] index,
    output logic [off_w-1:0] offset
);
    localparam int idx_lsb = off_w + 2;

    // ########################################################################
    // Request register
    // ########################################################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req <= '0;
        end else if (accept) begin
            req.addr <= fetch_addr;
        end
    end

    // ########################################################################
    // Address fields
    // ########################################################################

    // On the accept cycle the arrays read with the incoming index, so the
    // read data lines up with the stored request one edge later.
    always_comb begin
        if (accept) begin
            index = fetch_addr[idx_lsb+idx_w-1:idx_lsb];
        end else begin
            index = req.addr[idx_lsb+idx_w-1:idx_lsb];
        end
    end

    assign offset = req.addr[idx_lsb-1:2];  // Word within the line.

endmodule

//--- icache/icache_execute.sv
module icache_execute import icache_pkg::*; #(
    parameter int ways       = DEF_WAYS,
    parameter int sets       = DEF_SETS,
    parameter int line_words = DEF_LINE_WORDS,
    localparam int way_w     = $clog2(ways),
    localparam int idx_w     = $clog2(sets),
    localparam int off_w     = $clog2(line_words)
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [idx_w-1:0]       index,
    input  fetch_req_t             req,
    input  logic [off_w-1:0]       offset,
    input  logic                   fill_en,
    input  logic [ways-1:0]        fill_way,
    input  logic [idx_w-1:0]       fill_index,
    input  word_t [line_words-1:0] fill_line,
    input  logic                   inval_en,
    input  logic [idx_w-1:0]       inval_index,
    output logic                   hit,
    output logic [way_w-1:0]       hit_way,
    output word_t                  rdata
);
    localparam int tag_w = 32 - idx_w - off_w - 2;

    logic [tag_w-1:0]       req_tag;
    logic                   valid_q [ways];
    logic [tag_w-1:0]       tag_q [ways];
    word_t [line_words-1:0] line_q [ways];

    assign req_tag = req.addr[31:32-tag_w];

    // ########################################################################
    // Per-way storage
    // ########################################################################

    for (genvar w = 0; w < ways; w++) begin : g_way
        logic [sets-1:0]        valid;
        logic [tag_w-1:0]       tag_mem [sets];
        word_t [line_words-1:0] line_mem [sets];
        logic                   wr;

        assign wr = fill_en && fill_way[w];

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                valid      <= '0;
                valid_q[w] <= 1'b0;
            end else begin
                if (inval_en) begin
                    valid[inval_index] <= 1'b0;     // Fence clears one set per cycle.
                end else if (wr) begin
                    valid[fill_index] <= 1'b1;
                end
                valid_q[w] <= valid[index];
            end
        end

        // Tag of the refilled line comes from the request that missed.
        always_ff @(posedge clk) begin
            if (wr) begin
                tag_mem[fill_index]  <= req_tag;
                line_mem[fill_index] <= fill_line;
            end
            tag_q[w]  <= tag_mem[index];
            line_q[w] <= line_mem[index];
        end
    end

    // ########################################################################
    // Hit detection
    // ########################################################################

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < ways; w++) begin
            if (valid_q[w] && tag_q[w] == req_tag) begin
                hit     = 1'b1;
                hit_way = way_w'(w);
            end
        end
    end

    assign rdata = line_q[hit_way][offset];   // Only meaningful while hit is high.

endmodule

//--- icache/icache_result.sv
module icache_result import icache_pkg::*; #(
    parameter int ways       = DEF_WAYS,
    parameter int sets       = DEF_SETS,
    parameter int line_words = DEF_LINE_WORDS,
    localparam int way_w     = $clog2(ways),
    localparam int idx_w     = $clog2(sets),
    localparam int off_w     = $clog2(line_words)
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_req,
    output logic                   fetch_ack,
    output word_t                  fetch_data,
    input  logic                   fence_req,
    output logic                   fence_ack,
    output logic                   mem_req,
    output addr_t                  mem_addr,
    input  logic                   mem_ack,
    input  word_t                  mem_data,
    output logic                   accept,
    input  fetch_req_t             req,
    input  logic                   hit,
    input  logic [way_w-1:0]       hit_way,
    input  word_t                  rdata,
    input  logic [way_w-1:0]       victim,
    output logic                   plru_touch,
    output logic [way_w-1:0]       plru_way,
    output logic [idx_w-1:0]       plru_index,
    output logic                   fill_en,
    output logic [ways-1:0]        fill_way,
    output logic [idx_w-1:0]       fill_index,
    output word_t [line_words-1:0] fill_line,
    output logic                   inval_en,
    output logic [idx_w-1:0]       inval_index
);
    localparam int idx_lsb = off_w + 2;
    localparam int sweep_w = idx_w + 2;

    cache_state_t           state;
    logic [off_w-1:0]       word_cnt;
    logic [sweep_w-1:0]     sweep_cnt;
    logic                   last_word;
    logic [idx_w-1:0]       req_index;
    lookup_t                lk;
    word_t [line_words-1:0] line_buf;

    assign req_index = req.addr[idx_lsb+idx_w-1:idx_lsb];
    assign last_word = word_cnt == off_w'(line_words - 1);
    assign accept    = state == IDLE && fetch_req;

    // ########################################################################
    // Control FSM
    // ########################################################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            fetch_ack <= 1'b0;
            fence_ack <= 1'b0;
            mem_req   <= 1'b0;
            word_cnt  <= '0;
            sweep_cnt <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (fetch_req) begin
                        state <= LOOKUP;            // Fetch wins over fence.
                    end else if (fence_req) begin
                        sweep_cnt <= '0;
                        state     <= FENCE;
                    end
                end
                LOOKUP: begin
                    word_cnt <= '0;
                    state    <= hit ? RESPOND : MISS_REQ;
                end
                MISS_REQ: begin
                    mem_req <= 1'b1;
                    state   <= MISS_WAIT;
                end
                MISS_WAIT: begin
                    if (mem_req && mem_ack) begin
                        mem_req <= 1'b0;
                    end else if (!mem_req && !mem_ack) begin
                        if (last_word) begin
                            state <= RESPOND;       // Line is written this cycle.
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                            state    <= MISS_REQ;
                        end
                    end
                end
                RESPOND: begin
                    if (!fetch_ack) begin
                        fetch_ack <= 1'b1;
                    end else if (!fetch_req) begin
                        fetch_ack <= 1'b0;
                        state     <= IDLE;
                    end
                end
                FENCE: begin
                    // Sets are cleared first, then one spare cycle before the ack.
                    if (!fence_ack) begin
                        sweep_cnt <= sweep_cnt + 1'b1;
                        if (sweep_cnt == sweep_w'(sets + 1)) begin
                            fence_ack <= 1'b1;
                        end
                    end else if (!fence_req) begin
                        fence_ack <= 1'b0;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ########################################################################
    // Lookup register and refill buffer
    // ########################################################################

    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            lk <= '{hit: hit, data: rdata, addr: req.addr};
        end
        if (state == MISS_WAIT && mem_req && mem_ack) begin
            line_buf[word_cnt] <= mem_data;
        end
    end

    assign fetch_data = lk.hit ? lk.data : line_buf[lk.addr[idx_lsb-1:2]];
    assign mem_addr   = {lk.addr[31:idx_lsb], word_cnt, 2'b00};

    // ########################################################################
    // Array and PLRU control
    // ########################################################################

    assign fill_en     = state == MISS_WAIT && !mem_req && !mem_ack && last_word;
    assign fill_way    = {{(ways-1){1'b0}}, 1'b1} << victim;
    assign fill_index  = req_index;
    assign fill_line   = line_buf;

    assign inval_en    = state == FENCE && sweep_cnt < sweep_w'(sets);
    assign inval_index = sweep_cnt[idx_w-1:0];

    assign plru_touch  = (state == LOOKUP && hit) || fill_en;
    assign plru_way    = fill_en ? victim : hit_way;
    assign plru_index  = req_index;

endmodule

//--- icache/icache_top.sv
module icache_top import icache_pkg::*; #(
    parameter int ways       = DEF_WAYS,
    parameter int sets       = DEF_SETS,
    parameter int line_words = DEF_LINE_WORDS
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  fetch_req,
    input  addr_t fetch_addr,
    output logic  fetch_ack,
    output word_t fetch_data,
    input  logic  fence_req,
    output logic  fence_ack,
    output logic  mem_req,
    output addr_t mem_addr,
    input  logic  mem_ack,
    input  word_t mem_data
);
    localparam int way_w = $clog2(ways);
    localparam int idx_w = $clog2(sets);
    localparam int off_w = $clog2(line_words);

    logic                   accept;
    fetch_req_t             req;
    logic [idx_w-1:0]       index;
    logic [off_w-1:0]       offset;
    logic                   hit;
    logic [way_w-1:0]       hit_way;
    word_t                  rdata;
    logic [way_w-1:0]       victim;
    logic                   plru_touch;
    logic [way_w-1:0]       plru_way;
    logic [idx_w-1:0]       plru_index;
    logic                   fill_en;
    logic [ways-1:0]        fill_way;
    logic [idx_w-1:0]       fill_index;
    word_t [line_words-1:0] fill_line;
    logic                   inval_en;
    logic [idx_w-1:0]       inval_index;

    icache_decode #(.sets(sets), .line_words(line_words)) i_decode (
        .clk, .rst, .fetch_addr, .accept, .req, .index, .offset
    );

    icache_execute #(.ways(ways), .sets(sets), .line_words(line_words)) i_execute (
        .clk, .rst, .index, .req, .offset,
        .fill_en, .fill_way, .fill_index, .fill_line,
        .inval_en, .inval_index,
        .hit, .hit_way, .rdata
    );

    icache_result #(.ways(ways), .sets(sets), .line_words(line_words)) i_result (
        .clk, .rst,
        .fetch_req, .fetch_ack, .fetch_data,
        .fence_req, .fence_ack,
        .mem_req, .mem_addr, .mem_ack, .mem_data,
        .accept, .req, .hit, .hit_way, .rdata,
        .victim, .plru_touch, .plru_way, .plru_index,
        .fill_en, .fill_way, .fill_index, .fill_line,
        .inval_en, .inval_index
    );

    plru_tree #(.ways(ways), .sets(sets)) i_plru (
        .clk, .rst, .touch(plru_touch), .way(plru_way), .index(plru_index), .victim
    );

endmodule

//--- testbench/mem_model.sv
module mem_model import icache_pkg::*; #(
    parameter word_t key = 32'h5a3c_96e1
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       mem_req,
    input  addr_t      mem_addr,
    input  logic [1:0] delay,
    output logic       mem_ack,
    output word_t      mem_data
);
    logic  ack_q    = 1'b0;
    word_t data_q   = '0;
    int    wait_cnt = 0;

    assign mem_ack  = ack_q;
    assign mem_data = data_q;

    // Answers on the falling edge, so the cache sees a stable word at its rising edge.
    always @(negedge clk or posedge rst) begin
        if (rst) begin
            ack_q    <= 1'b0;
            data_q   <= '0;
            wait_cnt <= 0;
        end else if (mem_req && !ack_q) begin
            if (wait_cnt >= int'(delay)) begin
                ack_q    <= 1'b1;
                data_q   <= mem_addr ^ key;     // Contents follow from the address alone.
                wait_cnt <= 0;
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end else if (!mem_req && ack_q) begin
            ack_q <= 1'b0;
        end
    end

endmodule

//--- testbench/icache_tb.sv
module icache_tb import icache_pkg::*; ();

    localparam int    ways        = DEF_WAYS;
    localparam int    sets        = DEF_SETS;
    localparam int    line_words  = DEF_LINE_WORDS;
    localparam int    way_w       = $clog2(ways);
    localparam int    idx_lsb     = $clog2(line_words) + 2;
    localparam int    tag_lsb     = idx_lsb + $clog2(sets);
    localparam int    line_bytes  = 4 * line_words;
    localparam word_t mem_key     = 32'h5a3c_96e1;
    localparam addr_t span_base   = 32'h0000_8000;
    localparam int    span_words  = 3 * ways * sets * line_words / 2;  // Half again the capacity.
    localparam int    n_rand      = 300;
    localparam int    fence_every = 64;
    localparam int    fence_lines = 6;
    localparam int    miss_cycles = 12 + line_words * 8;
    localparam int    n_req       = n_rand + 2 * (ways + 1) + 2 * fence_lines;
    localparam int    n_fence     = n_rand / fence_every + 2;
    localparam int    cycle_limit = 20 + n_req * miss_cycles + n_fence * (sets + 8);

    logic            clk;
    logic            rst;
    logic            fetch_req;
    addr_t           fetch_addr;
    logic            fetch_ack;
    word_t           fetch_data;
    logic            fence_req;
    logic            fence_ack;
    logic            mem_req;
    addr_t           mem_addr;
    logic            mem_ack;
    word_t           mem_data;
    logic [1:0]      mem_delay    = '0;
    logic [31:0]     rng_state    = 32'h0bad_622f;
    int              cycles       = 0;
    logic            mem_req_seen = 1'b0;
    addr_t           mem_addrs [$];
    logic            model_valid [sets][ways];
    logic [31:0]     model_tag [sets][ways];
    logic [ways-2:0] model_tree [sets];

    icache_top #(.ways(ways), .sets(sets), .line_words(line_words)) i_dut (
        .clk, .rst, .fetch_req, .fetch_addr, .fetch_ack, .fetch_data,
        .fence_req, .fence_ack, .mem_req, .mem_addr, .mem_ack, .mem_data
    );

    mem_model #(.key(mem_key)) i_mem (
        .clk, .rst, .mem_req, .mem_addr, .delay(mem_delay), .mem_ack, .mem_data
    );

    // ##########################################################################
    // Clock, timeout and bus watchers
    // ##########################################################################

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        mem_delay <= 2'(rand_next());   // Fresh memory latency every cycle.
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    always @(negedge clk) begin
        if (mem_req && !mem_req_seen) begin
            mem_addrs.push_back(mem_addr);  // One entry per word handshake.
        end
        mem_req_seen = mem_req;
    end

    // ##########################################################################
    // Random numbers and checks
    // ##########################################################################

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] rand_next();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function addr_t rand_addr();
        return span_base + addr_t'((rand_next() % span_words) * 4);
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic check_outputs_low(input string name);
        check({name, " fetch_ack"}, 0, 32'(fetch_ack));
        check({name, " fence_ack"}, 0, 32'(fence_ack));
        check({name, " mem_req"}, 0, 32'(mem_req));
    endtask

    // ##########################################################################
    // Reference model
    // ##########################################################################

    function automatic int set_of(input addr_t a);
        return int'((a >> idx_lsb) % sets);
    endfunction

    function automatic int find_way(input addr_t a);
        for (int w = 0; w < ways; w++) begin
            if (model_valid[set_of(a)][w] && model_tag[set_of(a)][w] == (a >> tag_lsb)) begin
                return w;
            end
        end
        return -1;
    endfunction

    // Nodes are numbered as a heap with children 2m and 2m+1, and a set bit means go right.
    function automatic int pick_victim(input int set);
        int node;
        int v;
        int b;
        node = 1;
        v    = 0;
        for (int l = 0; l < way_w; l++) begin
            b    = int'(model_tree[set][node-1]);
            v    = 2 * v + b;
            node = 2 * node + b;
        end
        return v;
    endfunction

    task automatic touch_way(input int set, input int way);
        int node;
        int b;
        node = 1;
        for (int l = way_w - 1; l >= 0; l--) begin
            b = (way >> l) & 1;
            model_tree[set][node-1] = (b == 0);  // Point away from the used way.
            node = 2 * node + b;
        end
    endtask

    task automatic clear_valid();
        for (int s = 0; s < sets; s++) begin
            for (int w = 0; w < ways; w++) begin
                model_valid[s][w] = 1'b0;
            end
        end
    endtask

    // ##########################################################################
    // Bus drivers
    // ##########################################################################

    task automatic fetch(input string test, input addr_t a);
        int    way;
        int    set;
        int    edges;
        way = find_way(a);
        set = set_of(a);
        mem_addrs.delete();
        fetch_addr = a;
        fetch_req  = 1'b1;
        edges      = 0;
        do begin
            @(negedge clk);
            edges++;
        end while (!fetch_ack);
        check({test, " data"}, a ^ mem_key, fetch_data);
        if (way >= 0) begin
            check({test, " hit latency"}, 3, edges);
            check({test, " hit mem_req rises"}, 0, mem_addrs.size());
            touch_way(set, way);
        end else begin
            check({test, " miss mem_req rises"}, line_words, mem_addrs.size());
            for (int i = 0; i < line_words; i++) begin
                check({test, " refill address"}, (a & ~(line_bytes - 1)) + 4 * i, mem_addrs[i]);
            end
            way = pick_victim(set);
            model_valid[set][way] = 1'b1;
            model_tag[set][way]   = a >> tag_lsb;
            touch_way(set, way);
        end
        repeat (rand_next() % 3) begin  // The CPU is slow to drop its request.
            @(negedge clk);
            check({test, " held ack"}, 1, 32'(fetch_ack));
            check({test, " held data"}, a ^ mem_key, fetch_data);
        end
        fetch_req = 1'b0;
        do @(negedge clk); while (fetch_ack);
    endtask

    task automatic fence();
        fence_req = 1'b1;
        do @(negedge clk); while (!fence_ack);
        fence_req = 1'b0;
        do @(negedge clk); while (fence_ack);
        clear_valid();
    endtask

    // ##########################################################################
    // Tests
    // ##########################################################################

    task automatic replacement_test();
        addr_t lines [ways+1];
        addr_t gone;
        addr_t t;
        int    s;
        int    j;
        fence();
        s = int'(rand_next() % sets);
        for (int i = 0; i <= ways; i++) begin
            lines[i] = (addr_t'(32'h300 + i) << tag_lsb) | (addr_t'(s) << idx_lsb)
                     | addr_t'((rand_next() % line_words) * 4);
        end
        for (int i = ways; i > 0; i--) begin
            j        = int'(rand_next() % (i + 1));
            t        = lines[i];
            lines[i] = lines[j];
            lines[j] = t;
        end
        for (int i = 0; i <= ways; i++) begin
            fetch("replace fill", lines[i]);
        end
        gone = '0;
        for (int i = 0; i <= ways; i++) begin
            if (find_way(lines[i]) < 0) begin
                gone = lines[i];
            end
        end
        for (int i = 0; i <= ways; i++) begin
            if (lines[i] != gone) begin
                fetch("replace kept", lines[i]);
            end
        end
        fetch("replace evicted", gone);
    endtask

    task automatic fence_test();
        addr_t lines [fence_lines];
        addr_t base;
        base = rand_addr() & ~addr_t'(line_bytes - 1);
        for (int i = 0; i < fence_lines; i++) begin
            lines[i] = base + addr_t'(i * line_bytes) + addr_t'((rand_next() % line_words) * 4);
            fetch("fence fill", lines[i]);
        end
        fence();
        for (int i = 0; i < fence_lines; i++) begin
            fetch("after fence", lines[i]);   // Model holds no valid line, so each one misses.
        end
    endtask

    initial begin
        rst        = 1'b1;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        fence_req  = 1'b0;
        clear_valid();
        for (int s = 0; s < sets; s++) begin
            model_tree[s] = '0;
        end
        repeat (10) begin
            @(negedge clk);
            check_outputs_low("reset");
        end
        rst = 1'b0;
        @(negedge clk);
        check_outputs_low("after reset");
        for (int i = 0; i < n_rand; i++) begin
            if (i % fence_every == fence_every - 1) begin
                fence();
            end
            fetch("random", rand_addr());
        end
        replacement_test();
        fence_test();
        $display("TEST OK");
        $finish;
    end

endmodule

//--- icache_top.f
common/icache_pkg.sv
logic/plru_tree.sv
icache/icache_decode.sv
icache/icache_execute.sv
icache/icache_result.sv
icache/icache_top.sv
testbench/mem_model.sv
testbench/icache_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = icache_tb
FILELIST  = icache_top.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
